//--- common/fdc_pkg.sv
// Types shared by the MSX floppy cartridge blocks: the CPU access bundle,
// the drive-side bundles and the WD279x command, register and status codes.
package fdc_pkg;

   // One CPU access as presented by the cartridge slot
   typedef struct packed {
      logic [13:0] addr;
      logic [7:0]  data;
      logic        rd;
      logic        wr;
      logic        mreq;
   } host_bus_t;

   // Lines driven towards the floppy drive, dir high means towards the spindle
   typedef struct packed {
      logic step;
      logic dir;
      logic side;
      logic motor;
      logic sel_a;
      logic sel_b;
   } fdd_ctrl_t;

   // Lines coming back from the drive
   typedef struct packed {
      logic track0;
      logic wprot;
      logic disk_in;
   } fdd_stat_t;

   // Cartridge register layouts
   typedef enum logic {LAYOUT_PHILIPS, LAYOUT_NATIONAL} layout_e;

   typedef enum logic [1:0] {DRIVE_NONE, DRIVE_A, DRIVE_B} drive_sel_e;

   // Commands the core knows, decoded from the upper nibble of the command byte
   typedef enum logic [2:0] {
      CMD_RESTORE,
      CMD_SEEK,
      CMD_STEP,
      CMD_STEP_IN,
      CMD_STEP_OUT,
      CMD_FORCE_INT,
      CMD_UNSUPPORTED
   } fdc_cmd_e;

   // Controller register index, taken from the low address bits
   typedef enum logic [1:0] {REG_CMD_STATUS, REG_TRACK, REG_SECTOR, REG_DATA} fdc_reg_e;

   // Status register bit positions for type I commands
   localparam int ST_BUSY      = 0;
   localparam int ST_TRACK0    = 2;
   localparam int ST_SEEK_ERR  = 4;
   localparam int ST_WPROT     = 6;
   localparam int ST_NOT_READY = 7;

endpackage

//--- verilog/fdc_io_decode.sv
// Memory-mapped decode of the floppy cartridge for the Philips and National layouts.
// Holds the side, drive and motor registers and builds the read data for the CPU.
module fdc_io_decode (
   input  logic               cpu_bus,
   input  logic               rst_n,
   input  fdc_pkg::host_bus_t host,
   input  fdc_pkg::layout_e   layout,
   input  logic [7:0]         fdc_dout,
   input  logic               intrq,
   input  logic               disk_in,
   output logic               fdc_sel,
   output logic [1:0]         reg_idx,
   output logic               drive_ready,
   output logic               side,
   output logic               motor,
   output logic               sel_a,
   output logic               sel_b,
   output logic [7:0]         data,
   output logic               data_oe_rq
);
   import fdc_pkg::*;

   logic       area_philips;
   logic       area_national;
   logic       dev_cs;
   logic       ctrl_wr;
   logic [7:0] side_reg;
   logic [7:0] drive_reg;
   drive_sel_e drive;

   // Philips maps eight bytes at the top of the page, National a 128 byte window
   assign area_philips  = (host.addr[13:3] == '1) && (layout == LAYOUT_PHILIPS);
   assign area_national = (host.addr[13:7] == '1) && (layout == LAYOUT_NATIONAL);
   assign dev_cs        = (area_philips || area_national) && host.mreq;

   // In both layouts addr[2] low selects the controller itself
   assign fdc_sel = dev_cs && !host.addr[2];
   assign ctrl_wr = dev_cs && host.addr[2] && host.wr;
   assign reg_idx = host.addr[1:0];

   assign sel_a = (drive == DRIVE_A);
   assign sel_b = (drive == DRIVE_B);

   // Only drive A is wired to the media, so ready needs it selected and spinning
   assign drive_ready = disk_in && motor && (drive == DRIVE_A);

   always_ff @(posedge cpu_bus) begin
      if (!rst_n) begin
         side_reg  <= 8'h00;
         drive_reg <= 8'h00;
         drive     <= DRIVE_A;
         side      <= 1'b0;
         motor     <= 1'b0;
      end else if (ctrl_wr) begin
         if (area_philips) begin
            case (host.addr[1:0])
               2'd0: begin
                  // Only bit 0 of the side register reaches the drive
                  side_reg <= host.data;
                  side     <= host.data[0];
               end
               2'd1: begin
                  // Drive register carries the select code and the motor bit
                  drive_reg <= host.data;
                  motor     <= host.data[7];
                  case (host.data[1:0])
                     2'd0, 2'd2: drive <= DRIVE_A;
                     2'd1:       drive <= DRIVE_B;
                     default:    drive <= DRIVE_NONE;
                  endcase
               end
               default: ;
            endcase
         end else begin
            // National packs drive code, side and motor into a single byte
            case (host.data[1:0])
               2'd1:    drive <= DRIVE_A;
               2'd2:    drive <= DRIVE_B;
               default: drive <= DRIVE_NONE;
            endcase
            side  <= host.data[2];
            motor <= host.data[3];
         end
      end
   end

   // Read path is combinational so data is valid in the same cycle as rd
   always_comb begin
      data       = 8'hFF;
      data_oe_rq = 1'b0;
      if (dev_cs && host.rd) begin
         if (!host.addr[2]) begin
            data       = fdc_dout;
            data_oe_rq = 1'b1;
         end else if (area_philips) begin
            case (host.addr[1:0])
               2'd0: begin
                  data       = side_reg;
                  data_oe_rq = 1'b1;
               end
               2'd1: begin
                  data       = drive_reg & 8'hFB;
                  data_oe_rq = 1'b1;
               end
               2'd3: begin
                  // Bit 7 stands for inverted DRQ and stays at 1 without data transfer
                  data       = {1'b1, ~intrq, 6'h3F};
                  data_oe_rq = 1'b1;
               end
               default: ;
            endcase
         end else begin
            data       = {intrq, 1'b1, 6'h3F};
            data_oe_rq = 1'b1;
         end
      end
   end

   // A controller write leaves the drive-control registers untouched
   a_ctrl_hold: assert property (@(posedge cpu_bus) disable iff (!rst_n)
      (fdc_sel && host.wr) |=> ($stable(side) && $stable(motor) && $stable(drive)));

endmodule

//--- wd279x/wd279x_stepper.sv
// Step pulse generator for the drive head.
// Each request gives one step strobe, then STEP_CYCLES of settling before step_done.
module wd279x_stepper #(
   parameter int unsigned STEP_CYCLES = 8
) (
   input  logic cpu_bus,
   input  logic rst_n,
   input  logic step_req,
   input  logic step_dir,
   output logic step_done,
   output logic step,
   output logic dir
);

   localparam int unsigned CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

   logic [CNT_W-1:0] cnt;
   logic             busy;

   always_ff @(posedge cpu_bus) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         cnt       <= '0;
         step      <= 1'b0;
         step_done <= 1'b0;
         dir       <= 1'b0;
      end else begin
         // Both strobes last a single cycle
         step      <= 1'b0;
         step_done <= 1'b0;
         if (step_req && !busy) begin
            // Direction is held steady for the whole settling time
            busy <= 1'b1;
            step <= 1'b1;
            dir  <= step_dir;
            cnt  <= CNT_W'(STEP_CYCLES - 1);
         end else if (busy) begin
            if (cnt == '0) begin
               busy      <= 1'b0;
               step_done <= 1'b1;
            end else begin
               cnt <= cnt - 1'b1;
            end
         end
      end
   end

   // The requester has to wait for step_done before asking again
   a_no_overlap: assert property (@(posedge cpu_bus) disable iff (!rst_n)
      step_req |-> !busy);

endmodule

//--- wd279x/wd279x_core.sv
// WD279x-style controller core limited to type I head positioning and force interrupt.
// Holds the track, sector, data and status registers and requests single steps
// from the stepper, one at a time.
module wd279x_core (
   input  logic               cpu_bus,
   input  logic               rst_n,
   input  logic               fdc_sel,
   input  logic [1:0]         reg_idx,
   input  fdc_pkg::host_bus_t host,
   input  logic               drive_ready,
   input  fdc_pkg::fdd_stat_t fdd_stat,
   input  logic               step_done,
   output logic               step_req,
   output logic               step_dir,
   output logic [7:0]         fdc_dout,
   output logic               intrq
);
   import fdc_pkg::*;

   typedef enum logic [1:0] {IDLE, PREP, STEP_WAIT, DONE} core_state_e;

   core_state_e state;
   fdc_cmd_e    cmd_q;
   fdc_cmd_e    cmd_dec;
   logic        u_q;
   logic [7:0]  track_q;
   logic [7:0]  sector_q;
   logic [7:0]  data_q;
   logic [7:0]  step_cnt;
   logic        seek_err;
   logic        dir_q;
   logic        step_pend;
   logic        busy;
   logic        cmd_wr;
   logic        fint_wr;
   logic        stat_rd;
   logic        need_step;
   logic        track_upd;
   logic [7:0]  status;

   assign cmd_wr  = fdc_sel && host.wr && (fdc_reg_e'(reg_idx) == REG_CMD_STATUS);
   assign stat_rd = fdc_sel && host.rd && (fdc_reg_e'(reg_idx) == REG_CMD_STATUS);
   assign fint_wr = cmd_wr && (cmd_dec == CMD_FORCE_INT);
   assign busy    = (state != IDLE);

   // Upper nibble picks the command, type II and III all fall into unsupported
   always_comb begin
      case (host.data[7:4])
         4'h0:       cmd_dec = CMD_RESTORE;
         4'h1:       cmd_dec = CMD_SEEK;
         4'h2, 4'h3: cmd_dec = CMD_STEP;
         4'h4, 4'h5: cmd_dec = CMD_STEP_IN;
         4'h6, 4'h7: cmd_dec = CMD_STEP_OUT;
         4'hD:       cmd_dec = CMD_FORCE_INT;
         default:    cmd_dec = CMD_UNSUPPORTED;
      endcase
   end

   // Whether the running command still wants another step, and which way
   always_comb begin
      need_step = 1'b0;
      step_dir  = dir_q;
      track_upd = 1'b0;
      case (cmd_q)
         CMD_RESTORE: begin
            // Give up after 255 steps without seeing track 0
            need_step = !fdd_stat.track0 && (step_cnt != 8'hFF);
            step_dir  = 1'b0;
         end
         CMD_SEEK: begin
            need_step = (track_q != data_q);
            step_dir  = (data_q > track_q);
            track_upd = 1'b1;
         end
         CMD_STEP: begin
            need_step = (step_cnt == 8'h00);
            track_upd = u_q;
         end
         CMD_STEP_IN: begin
            need_step = (step_cnt == 8'h00);
            step_dir  = 1'b1;
            track_upd = u_q;
         end
         CMD_STEP_OUT: begin
            need_step = (step_cnt == 8'h00);
            step_dir  = 1'b0;
            track_upd = u_q;
         end
         default: ;
      endcase
   end

   // A step left over from an interrupted command must finish before a new one
   assign step_req = (state == PREP) && need_step && !step_pend && !fint_wr;

   always_ff @(posedge cpu_bus) begin
      if (fdc_sel && host.wr) begin
         case (fdc_reg_e'(reg_idx))
            REG_SECTOR: sector_q <= host.data;
            REG_DATA:   data_q   <= host.data;
            default: ;
         endcase
      end
   end

   always_ff @(posedge cpu_bus) begin
      if (!rst_n) begin
         state     <= IDLE;
         cmd_q     <= CMD_RESTORE;
         u_q       <= 1'b0;
         track_q   <= 8'h00;
         step_cnt  <= 8'h00;
         seek_err  <= 1'b0;
         dir_q     <= 1'b0;
         step_pend <= 1'b0;
         intrq     <= 1'b0;
      end else begin
         if (fdc_sel && host.wr && (fdc_reg_e'(reg_idx) == REG_TRACK))
            track_q <= host.data;
         if (stat_rd || cmd_wr)
            intrq <= 1'b0;
         if (step_req)
            step_pend <= 1'b1;
         else if (step_done)
            step_pend <= 1'b0;

         if (fint_wr) begin
            // Force interrupt aborts whatever runs and flags completion at once
            state <= IDLE;
            intrq <= 1'b1;
         end else begin
            case (state)
               IDLE: begin
                  if (cmd_wr) begin
                     cmd_q    <= cmd_dec;
                     u_q      <= host.data[4];
                     step_cnt <= 8'h00;
                     seek_err <= (cmd_dec == CMD_UNSUPPORTED);
                     state    <= (cmd_dec == CMD_UNSUPPORTED) ? DONE : PREP;
                  end
               end
               PREP: begin
                  if (need_step) begin
                     if (step_req) begin
                        step_cnt <= step_cnt + 8'd1;
                        dir_q    <= step_dir;
                        if (track_upd)
                           track_q <= step_dir ? track_q + 8'd1 : track_q - 8'd1;
                        state <= STEP_WAIT;
                     end
                  end else begin
                     // Restore always leaves track 0 in the register
                     if (cmd_q == CMD_RESTORE) begin
                        track_q  <= 8'h00;
                        seek_err <= !fdd_stat.track0;
                     end
                     state <= DONE;
                  end
               end
               STEP_WAIT: begin
                  if (step_done)
                     state <= PREP;
               end
               default: begin
                  // intrq rises on the same edge that drops busy
                  intrq <= 1'b1;
                  state <= IDLE;
               end
            endcase
         end
      end
   end

   // Drive lines are passed through live, the error bit is latched
   always_comb begin
      status               = 8'h00;
      status[ST_BUSY]      = busy;
      status[ST_TRACK0]    = fdd_stat.track0;
      status[ST_SEEK_ERR]  = seek_err;
      status[ST_WPROT]     = fdd_stat.wprot;
      status[ST_NOT_READY] = ~drive_ready;
   end

   always_comb begin
      case (fdc_reg_e'(reg_idx))
         REG_CMD_STATUS: fdc_dout = status;
         REG_TRACK:      fdc_dout = track_q;
         REG_SECTOR:     fdc_dout = sector_q;
         default:        fdc_dout = data_q;
      endcase
   end

   // Every completion from the stepper answers a request this core made
   a_done_has_req: assert property (@(posedge cpu_bus) disable iff (!rst_n)
      step_done |-> step_pend);

endmodule

//--- verilog/msx_fdc.sv
// Top level of the MSX disk cartridge floppy interface.
// Joins the address decoder, the WD279x core and the head stepper.
module msx_fdc #(
   parameter int unsigned STEP_CYCLES = 8
) (
   input  logic               cpu_bus,
   input  logic               rst_n,
   input  fdc_pkg::host_bus_t host,
   input  fdc_pkg::layout_e   layout,
   input  fdc_pkg::fdd_stat_t fdd_stat,
   output fdc_pkg::fdd_ctrl_t fdd_ctrl,
   output logic [7:0]         data,
   output logic               data_oe_rq
);

   logic       fdc_sel;
   logic [1:0] reg_idx;
   logic       drive_ready;
   logic       side;
   logic       motor;
   logic       sel_a;
   logic       sel_b;
   logic [7:0] fdc_dout;
   logic       intrq;
   logic       step_req;
   logic       step_dir;
   logic       step_done;
   logic       step;
   logic       dir;

   fdc_io_decode i_fdc_io_decode (
      .cpu_bus     (cpu_bus),
      .rst_n       (rst_n),
      .host        (host),
      .layout      (layout),
      .fdc_dout    (fdc_dout),
      .intrq       (intrq),
      .disk_in     (fdd_stat.disk_in),
      .fdc_sel     (fdc_sel),
      .reg_idx     (reg_idx),
      .drive_ready (drive_ready),
      .side        (side),
      .motor       (motor),
      .sel_a       (sel_a),
      .sel_b       (sel_b),
      .data        (data),
      .data_oe_rq  (data_oe_rq)
   );

   wd279x_core i_wd279x_core (
      .cpu_bus     (cpu_bus),
      .rst_n       (rst_n),
      .fdc_sel     (fdc_sel),
      .reg_idx     (reg_idx),
      .host        (host),
      .drive_ready (drive_ready),
      .fdd_stat    (fdd_stat),
      .step_done   (step_done),
      .step_req    (step_req),
      .step_dir    (step_dir),
      .fdc_dout    (fdc_dout),
      .intrq       (intrq)
   );

   // Step timing is only known here and is handed down to the stepper
   wd279x_stepper #(
      .STEP_CYCLES (STEP_CYCLES)
   ) i_wd279x_stepper (
      .cpu_bus   (cpu_bus),
      .rst_n     (rst_n),
      .step_req  (step_req),
      .step_dir  (step_dir),
      .step_done (step_done),
      .step      (step),
      .dir       (dir)
   );

   // Drive-side bundle
   assign fdd_ctrl = '{step: step, dir: dir, side: side, motor: motor,
                       sel_a: sel_a, sel_b: sel_b};

endmodule

//--- bench/tb_msx_fdc.sv
// Testbench for the MSX floppy cartridge interface.
// Drives CPU accesses in both cartridge layouts, models the drive head and
// checks register access, type I commands and force interrupt.
module tb_msx_fdc;
   import fdc_pkg::*;

   localparam int unsigned STEP_CYCLES = 8;
   // Worst case is the start seek, the restore, the seek, five single steps and the long seek
   localparam int unsigned PLANNED_STEPS = 79 + 79 + 79 + 5 + 79;
   localparam int unsigned TIMEOUT_CYCLES = PLANNED_STEPS * (STEP_CYCLES + 2) + 2000;
   localparam int WAIT_LIMIT = 100 * (STEP_CYCLES + 2);

   // Philips window sits at the top eight bytes, National at the top 128
   localparam logic [13:0] PH_FDC    = 14'h3FF8;
   localparam logic [13:0] PH_TRACK  = 14'h3FF9;
   localparam logic [13:0] PH_DATA   = 14'h3FFB;
   localparam logic [13:0] PH_SIDE   = 14'h3FFC;
   localparam logic [13:0] PH_DRIVE  = 14'h3FFD;
   localparam logic [13:0] PH_STATUS = 14'h3FFF;
   localparam logic [13:0] NA_FDC    = 14'h3F80;
   localparam logic [13:0] NA_CTRL   = 14'h3F84;
   localparam logic [7:0] STEP_CMDS [5] = '{8'h40, 8'h50, 8'h60, 8'h70, 8'h30};

   logic        cpu_bus;
   logic        rst_n;
   host_bus_t   host;
   layout_e     layout;
   fdd_stat_t   fdd_stat;
   fdd_ctrl_t   fdd_ctrl;
   logic [7:0]  data;
   logic        data_oe_rq;
   logic        wprot;
   logic        disk_in;
   int          head = 0;
   int          in_steps = 0;
   int          out_steps = 0;
   int          errors = 0;
   int          passed = 0;
   int          failed = 0;
   int unsigned cycles = 0;
   logic        in_restore = 1'b0;
   logic        quiet = 1'b0;
   logic [31:0] rng = 32'hcb332abe;

   msx_fdc #(.STEP_CYCLES(STEP_CYCLES)) i_msx_fdc (
      .cpu_bus    (cpu_bus),
      .rst_n      (rst_n),
      .host       (host),
      .layout     (layout),
      .fdd_stat   (fdd_stat),
      .fdd_ctrl   (fdd_ctrl),
      .data       (data),
      .data_oe_rq (data_oe_rq)
   );

   initial begin
      cpu_bus = 1'b0;
      forever #5 cpu_bus = ~cpu_bus;
   end

   // The drive model stops the head at the mechanical ends and keeps cumulative step counts
   assign fdd_stat = '{track0: (head == 0), wprot: wprot, disk_in: disk_in};

   always @(posedge cpu_bus) begin
      if (rst_n && fdd_ctrl.step) begin
         if (fdd_ctrl.dir) begin
            in_steps <= in_steps + 1;
            if (head < 79)
               head <= head + 1;
         end else begin
            out_steps <= out_steps + 1;
            if (head > 0)
               head <= head - 1;
         end
      end
   end

   always @(posedge cpu_bus) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // The read mux parks the bus at FF whenever it does not drive
   a_bus_idle: assert property (@(posedge cpu_bus) disable iff (!rst_n)
      !data_oe_rq |-> (data == 8'hFF))
      else begin
         $display("FAIL data expected ff got %h", data);
         errors++;
      end

   // Restore only ever moves the head outward
   a_restore_dir: assert property (@(posedge cpu_bus) disable iff (!rst_n)
      (in_restore && fdd_ctrl.step) |-> !fdd_ctrl.dir)
      else begin
         $display("FAIL fdd_ctrl.dir expected 0 got 1");
         errors++;
      end

   a_no_step: assert property (@(posedge cpu_bus) disable iff (!rst_n)
      quiet |-> !fdd_ctrl.step)
      else begin
         $display("FAIL fdd_ctrl.step expected 0 got 1");
         errors++;
      end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic host_bus_t bus_word(input logic [13:0] a, input logic [7:0] d,
                                          input logic rd, input logic wr);
      return '{addr: a, data: d, rd: rd, wr: wr, mreq: 1'b1};
   endfunction

   task automatic check_hex(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
      assert (actual === expected)
      else begin
         $display("FAIL %s expected %h got %h", name, expected, actual);
         errors++;
      end
   endtask

   // The write pulse lasts one cycle until the next access or idle replaces it
   task automatic bus_write(input logic [13:0] a, input logic [7:0] d);
      @(posedge cpu_bus);
      host <= bus_word(a, d, 1'b0, 1'b1);
   endtask

   task automatic bus_idle();
      @(posedge cpu_bus);
      host <= '0;
      @(negedge cpu_bus);
   endtask

   // Read data is combinational, so it is sampled half a cycle later
   task automatic bus_read(input logic [13:0] a, output logic [7:0] d, output logic oe);
      @(posedge cpu_bus);
      host <= bus_word(a, 8'h00, 1'b1, 1'b0);
      @(negedge cpu_bus);
      d  = data;
      oe = data_oe_rq;
   endtask

   task automatic read_expect(input logic [13:0] a, input string name,
                              input logic [7:0] mask, input logic [7:0] expected);
      logic [7:0] d;
      logic       oe;
      bus_read(a, d, oe);
      check_hex(name, expected, d & mask);
      check_hex("data_oe_rq", 8'h01, {7'b0, oe});
   endtask

   // Polls the Philips status byte, whose bit 6 is inverted intrq
   task automatic wait_intrq();
      int n;
      n = 0;
      @(posedge cpu_bus);
      host <= bus_word(PH_STATUS, 8'h00, 1'b1, 1'b0);
      @(negedge cpu_bus);
      while (data[6] && n < WAIT_LIMIT) begin
         @(negedge cpu_bus);
         n++;
      end
      if (data[6]) begin
         $display("timeout: intrq did not rise within %0d cycles", WAIT_LIMIT);
         errors++;
      end
   endtask

   task automatic run_cmd(input logic [7:0] cmd);
      bus_write(PH_FDC, cmd);
      wait_intrq();
   endtask

   task automatic set_layout(input layout_e l);
      @(posedge cpu_bus);
      layout <= l;
      host   <= '0;
   endtask

   task automatic end_test(input string name, input int mark);
      if (errors == mark) begin
         passed++;
         $display("test %s: passed", name);
      end else begin
         failed++;
         $display("test %s: failed with %0d errors", name, errors - mark);
      end
   endtask

   initial begin
      logic [7:0] wval;
      logic [7:0] start_trk;
      logic [7:0] target;
      logic [7:0] exp_track;
      logic [7:0] d;
      logic       oe;
      logic       last_in;
      int         mark;
      int         k;
      int         delta;
      int         base_in;
      int         base_out;
      int         snap;

      host    = '0;
      layout  = LAYOUT_PHILIPS;
      wprot   = 1'b0;
      disk_in = 1'b1;
      rst_n   = 1'b0;
      repeat (3) @(posedge cpu_bus);
      rst_n <= 1'b1;
      bus_idle();

      mark = errors;
      bus_write(PH_SIDE, 8'h5A);
      read_expect(PH_SIDE, "side_reg", 8'hFF, 8'h5A);
      check_hex("fdd_ctrl.side", 8'h00, {7'b0, fdd_ctrl.side});
      bus_write(PH_SIDE, 8'hA5);
      read_expect(PH_SIDE, "side_reg", 8'hFF, 8'hA5);
      check_hex("fdd_ctrl.side", 8'h01, {7'b0, fdd_ctrl.side});
      for (k = 0; k < 4; k++) begin
         // Bit 2 is always written set to see it masked on readback
         wval = 8'h04 | 8'(k) | (k[0] ? 8'h00 : 8'h80);
         bus_write(PH_DRIVE, wval);
         read_expect(PH_DRIVE, "drive_reg", 8'hFF, {wval[7:3], 1'b0, wval[1:0]});
         check_hex("fdd_ctrl.motor", {7'b0, wval[7]}, {7'b0, fdd_ctrl.motor});
         check_hex("fdd_ctrl.sel_a", {7'b0, (k == 0 || k == 2)}, {7'b0, fdd_ctrl.sel_a});
         check_hex("fdd_ctrl.sel_b", {7'b0, (k == 1)}, {7'b0, fdd_ctrl.sel_b});
      end
      end_test("philips control registers", mark);

      mark = errors;
      set_layout(LAYOUT_NATIONAL);
      for (k = 0; k < 4; k++) begin
         wval = 8'(k) | (k[0] ? 8'h08 : 8'h00) | (k[1] ? 8'h00 : 8'h04);
         bus_write(NA_CTRL, wval);
         bus_idle();
         check_hex("fdd_ctrl.sel_a", {7'b0, (k == 1)}, {7'b0, fdd_ctrl.sel_a});
         check_hex("fdd_ctrl.sel_b", {7'b0, (k == 2)}, {7'b0, fdd_ctrl.sel_b});
         check_hex("fdd_ctrl.side", {7'b0, wval[2]}, {7'b0, fdd_ctrl.side});
         check_hex("fdd_ctrl.motor", {7'b0, wval[3]}, {7'b0, fdd_ctrl.motor});
      end
      // Force interrupt from idle raises intrq, a controller status read drops it
      bus_write(NA_FDC, 8'hD0);
      read_expect(NA_CTRL, "national status", 8'hFF, 8'hFF);
      read_expect(NA_FDC, "status busy", 8'h01, 8'h00);
      read_expect(NA_CTRL, "national status", 8'hFF, 8'h7F);
      bus_read(14'h0123, d, oe);
      check_hex("data", 8'hFF, d);
      check_hex("data_oe_rq", 8'h00, {7'b0, oe});
      bus_read(14'h3F00, d, oe);
      check_hex("data", 8'hFF, d);
      check_hex("data_oe_rq", 8'h00, {7'b0, oe});
      set_layout(LAYOUT_PHILIPS);
      end_test("national layout", mark);

      mark = errors;
      for (k = 0; k < 8; k++) begin
         // Bit 0 is disk_in and write protect, bit 1 the motor, bit 2 picks drive B
         bus_write(PH_DRIVE, {k[1], 6'b0, k[2]});
         disk_in <= k[0];
         wprot   <= k[0];
         read_expect(PH_FDC, "status not ready and wprot", 8'hC0,
                     {!(k[0] && k[1] && !k[2]), k[0], 6'b0});
      end
      bus_write(PH_DRIVE, 8'h80);
      disk_in <= 1'b1;
      wprot   <= 1'b0;
      rng = xorshift32(rng);
      start_trk = 8'(5 + rng % 70);
      bus_write(PH_DATA, start_trk);
      run_cmd(8'h10);
      check_hex("head position", start_trk, 8'(head));
      base_in    = in_steps;
      base_out   = out_steps;
      in_restore = 1'b1;
      run_cmd(8'h00);
      in_restore = 1'b0;
      check_hex("outward steps", start_trk, 8'(out_steps - base_out));
      check_hex("inward steps", 8'h00, 8'(in_steps - base_in));
      read_expect(PH_TRACK, "track register", 8'hFF, 8'h00);
      read_expect(PH_FDC, "status track0 and busy", 8'h05, 8'h04);
      exp_track = 8'h00;
      end_test("restore", mark);

      mark = errors;
      rng = xorshift32(rng);
      target   = 8'(5 + rng % 70);
      base_in  = in_steps;
      base_out = out_steps;
      bus_write(PH_DATA, target);
      run_cmd(8'h10);
      check_hex("net head movement", target - exp_track,
                8'((in_steps - base_in) - (out_steps - base_out)));
      read_expect(PH_TRACK, "track register", 8'hFF, target);
      read_expect(PH_FDC, "status busy", 8'h01, 8'h00);
      read_expect(PH_STATUS, "philips status", 8'hFF, 8'hFF);
      exp_track = target;
      last_in   = (target > 8'h00);
      end_test("seek", mark);

      mark = errors;
      for (k = 0; k < 5; k++) begin
         // Step-in and step-out set the direction, plain step keeps the last one
         if (STEP_CMDS[k][6:5] == 2'b10)
            last_in = 1'b1;
         else if (STEP_CMDS[k][6:5] == 2'b11)
            last_in = 1'b0;
         delta    = last_in ? 1 : -1;
         base_in  = in_steps;
         base_out = out_steps;
         run_cmd(STEP_CMDS[k]);
         if (STEP_CMDS[k][4])
            exp_track = exp_track + 8'(delta);
         check_hex("head movement", 8'(delta), 8'((in_steps - base_in) - (out_steps - base_out)));
         read_expect(PH_TRACK, "track register", 8'hFF, exp_track);
      end
      end_test("single steps", mark);

      mark = errors;
      target   = (exp_track < 8'd40) ? 8'd79 : 8'd0;
      base_in  = in_steps;
      base_out = out_steps;
      bus_write(PH_DATA, target);
      bus_write(PH_FDC, 8'h10);
      bus_idle();
      k = 0;
      while ((in_steps + out_steps - base_in - base_out) < 2 && k < WAIT_LIMIT) begin
         @(negedge cpu_bus);
         k++;
      end
      assert ((in_steps + out_steps - base_in - base_out) >= 2)
      else begin
         $display("the long seek did not start stepping before the force interrupt");
         errors++;
      end
      // The seek is still far from its target when it gets interrupted
      bus_write(PH_FDC, 8'hD0);
      read_expect(PH_STATUS, "philips status", 8'hFF, 8'hBF);
      quiet = 1'b1;
      snap  = in_steps + out_steps;
      read_expect(PH_FDC, "status busy", 8'h01, 8'h00);
      repeat (4 * (STEP_CYCLES + 2)) @(negedge cpu_bus);
      check_hex("step strobe count", 8'(snap), 8'(in_steps + out_steps));
      // A read sector command is not supported and ends with record not found
      run_cmd(8'h80);
      read_expect(PH_FDC, "status rnf and busy", 8'h11, 8'h10);
      check_hex("step strobe count", 8'(snap), 8'(in_steps + out_steps));
      quiet = 1'b0;
      end_test("force interrupt and unsupported", mark);

      $display("tests passed %0d, tests failed %0d, failed checks %0d", passed, failed, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- verilog.f
common/fdc_pkg.sv
verilog/fdc_io_decode.sv
wd279x/wd279x_stepper.sv
wd279x/wd279x_core.sv
verilog/msx_fdc.sv
bench/tb_msx_fdc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the floppy interface testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
   --top-module tb_msx_fdc \
   -f verilog.f \
   -Mdir obj_dir -o sim_msx_fdc

./obj_dir/sim_msx_fdc | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "simulation failed"
   exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

echo "simulation passed"
